/* cpu_pkg.sv */
package cpu_pkg;

    // widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 1 << reg_addr_w;
    localparam int mem_words  = 256;  // per memory
    localparam int mem_addr_w = 8;    // word index

    // instruction field positions
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int alt_bit    = 30;  // funct7[5], sub / sra select

    // ecall halts only when x17 == 10
    localparam logic [reg_addr_w-1:0] halt_reg  = 5'd17;
    localparam logic [xlen-1:0]       halt_code = 32'd10;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_e;

    typedef struct packed {
        logic    alu_src;     // 1: immediate operand b
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
    } id_ex_t;

    typedef struct packed {
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  reg_write;
        logic                  halt;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  halt;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;  // final write-back value
    } wb_t;

endpackage

/* pipe_control.sv */
`timescale 1ns/1ps

module pipe_control import cpu_pkg::*; (
    input  logic [xlen-1:0]       if_inst,
    input  logic [xlen-1:0]       rs1_data,   // write-through value, halt test only
    input  id_ex_t                id_ex,
    input  ex_mem_t               ex_mem,
    input  wb_t                   wb,
    output ctrl_t                 ctrl,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic                  stall,
    output fwd_sel_e              fwd_a,
    output fwd_sel_e              fwd_b
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       is_ecall;
    logic       uses_rs1, uses_rs2;
    logic       load_use;
    logic       ecall_wait;

    // funct3 to alu function, sub only for register form
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic allow_sub);
        case (f3)
            3'b000:  return (alt && allow_sub) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // newest writer wins, x0 never forwarded
    function automatic fwd_sel_e fwd_pick(input logic [reg_addr_w-1:0] src, input ex_mem_t exm,
                                          input wb_t w);
        if (exm.reg_write && exm.rd != '0 && exm.rd == src)
            return fwd_ex_mem;
        else if (w.reg_write && w.rd != '0 && w.rd == src)
            return fwd_mem_wb;
        return fwd_none;
    endfunction

    assign opcode   = opcode_e'(if_inst[6:0]);
    assign funct3   = if_inst[funct3_lsb +: 3];
    assign is_ecall = (opcode == op_system);

    // ecall reads x17 through the rs1 port
    assign rs1_addr = is_ecall ? halt_reg : if_inst[rs1_lsb +: reg_addr_w];
    assign rs2_addr = if_inst[rs2_lsb +: reg_addr_w];

    always_comb begin
        ctrl     = '0;  // unknown opcodes fall out as nops
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, if_inst[alt_bit], 1'b1);
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            op_imm: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, if_inst[alt_bit], 1'b0);
                uses_rs1       = 1'b1;
            end
            op_load: begin
                ctrl.alu_src    = 1'b1;  // base + offset
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                uses_rs1        = 1'b1;
            end
            op_store: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;  // store data
            end
            op_system: begin
                ctrl.halt = (rs1_data == halt_code);  // else a plain nop
                uses_rs1  = 1'b1;
            end
            default: ;
        endcase
    end

    // load in EX whose rd feeds the instruction in decode
    assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                      ((uses_rs1 && id_ex.rd == rs1_addr) ||
                       (uses_rs2 && id_ex.rd == rs2_addr));

    // x17 not yet visible through write-through
    assign ecall_wait = is_ecall &&
                        ((id_ex.ctrl.reg_write && id_ex.rd == halt_reg) ||
                         (ex_mem.reg_write && ex_mem.rd == halt_reg));

    assign stall = load_use || ecall_wait;

    assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, wb);
    assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, wb);

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  load_en,
    input  logic [mem_addr_w-1:0] load_addr,
    input  logic [xlen-1:0]       load_data,
    output logic [xlen-1:0]       if_inst    // IF/ID register
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [mem_words];
    logic [xlen-1:0] fetch_word;

    // program load, only while reset is held
    always_ff @(posedge clk) begin
        if (reset && load_en)
            imem[load_addr] <= load_data;
    end

    assign fetch_word = imem[pc[mem_addr_w+1:2]];  // async read, word index

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + xlen'(4);
        end
    end

    // zero word decodes as a nop
    always_ff @(posedge clk) begin
        if (reset) begin
            if_inst <= '0;
        end else if (!stall) begin
            if_inst <= fetch_word;  // hold on stall
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [xlen-1:0]       if_inst,
    input  ctrl_t                 ctrl,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  wb_t                   wb,
    output logic [xlen-1:0]       rs1_data,
    output id_ex_t                id_ex,
    output logic [xlen-1:0]       print_reg [num_regs]
);

    logic [xlen-1:0] regs [num_regs];
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm_i, imm_s;
    logic            wb_hit1, wb_hit2;
    id_ex_t          id_ex_next;

    // register file, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign print_reg = regs;

    // write-through: same-cycle write shows up on the read port
    assign wb_hit1  = wb.reg_write && wb.rd != '0 && wb.rd == rs1_addr;
    assign wb_hit2  = wb.reg_write && wb.rd != '0 && wb.rd == rs2_addr;
    assign rs1_data = wb_hit1 ? wb.data : regs[rs1_addr];
    assign rs2_data = wb_hit2 ? wb.data : regs[rs2_addr];

    // sign-extended immediates
    assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};

    always_comb begin
        id_ex_next          = '0;
        id_ex_next.ctrl     = ctrl;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
        id_ex_next.imm      = ctrl.mem_write ? imm_s : imm_i;  // store uses S-type
        id_ex_next.rd       = if_inst[rd_lsb +: reg_addr_w];
        id_ex_next.rs1      = rs1_addr;
        id_ex_next.rs2      = rs2_addr;
        if (stall) begin
            id_ex_next.ctrl = '0;  // bubble
            id_ex_next.rd   = '0;
        end
    end

    // ID/EX
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  wb_t      wb,
    output ex_mem_t  ex_mem
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;   // also the store data
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_y;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [xlen-1:0] id_val,
                                                input logic [xlen-1:0] exm_val,
                                                input logic [xlen-1:0] wb_val);
        case (sel)
            fwd_ex_mem: return exm_val;
            fwd_mem_wb: return wb_val;
            default:    return id_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb.data);
    assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb.data);
    assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;
    assign shamt   = op_b[4:0];  // low five bits only

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:  alu_y = op_a + op_b;
            alu_sub:  alu_y = op_a - op_b;
            alu_sll:  alu_y = op_a << shamt;
            alu_slt:  alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_y = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_y = op_a ^ op_b;
            alu_srl:  alu_y = op_a >> shamt;
            alu_sra:  alu_y = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_y = op_a | op_b;
            alu_and:  alu_y = op_a & op_b;
            default:  alu_y = op_a + op_b;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.halt       <= id_ex.ctrl.halt;
            ex_mem.alu_result <= alu_y;    // address for loads and stores
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output wb_t     wb      // MEM/WB register
);

    logic [xlen-1:0]       dmem [mem_words];
    logic [mem_addr_w-1:0] word_idx;
    logic [xlen-1:0]       load_word;

    assign word_idx = ex_mem.alu_result[mem_addr_w+1:2];  // byte address bits 9..2

    // word store
    always_ff @(posedge clk) begin
        if (ex_mem.mem_write)
            dmem[word_idx] <= ex_mem.store_data;
    end

    assign load_word = ex_mem.mem_read ? dmem[word_idx] : '0;  // async read

    // single write-back select here, not in WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.reg_write <= ex_mem.reg_write;
            wb.halt      <= ex_mem.halt;
            wb.rd        <= ex_mem.rd;
            wb.data      <= ex_mem.mem_to_reg ? load_word : ex_mem.alu_result;
        end
    end

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_en,     // program load, honored in reset
    input  logic [mem_addr_w-1:0] load_addr,
    input  logic [xlen-1:0]       load_data,
    output logic                  is_halted,
    output logic [xlen-1:0]       print_reg [num_regs]
);

    logic [xlen-1:0]       if_inst;
    logic [xlen-1:0]       rs1_data;
    logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
    logic                  stall;
    ctrl_t                 ctrl;
    fwd_sel_e              fwd_a, fwd_b;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    wb_t                   wb;

    fetch_stage u_fetch (
        .clk, .reset, .stall, .load_en, .load_addr, .load_data, .if_inst
    );

    pipe_control u_ctrl (
        .if_inst, .rs1_data, .id_ex, .ex_mem, .wb,
        .ctrl, .rs1_addr, .rs2_addr, .stall, .fwd_a, .fwd_b
    );

    decode_stage u_decode (
        .clk, .reset, .stall, .if_inst, .ctrl, .rs1_addr, .rs2_addr, .wb,
        .rs1_data, .id_ex, .print_reg
    );

    execute_stage u_execute (.clk, .reset, .id_ex, .fwd_a, .fwd_b, .wb, .ex_mem);

    memory_stage u_memory (.clk, .reset, .ex_mem, .wb);

    assign is_halted = wb.halt;  // halting ecall in MEM/WB

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            is_halted,
    input  logic [xlen-1:0] print_reg [num_regs],
    input  logic [xlen-1:0] exp_regs [num_regs],
    input  int              test_id,
    output logic            test_done,   // this test reported
    output int              pass_count,
    output int              fail_count
);

    logic armed;        // waiting for the halt
    logic first_cycle;  // first cycle out of reset
    int   passes = 0;
    int   fails  = 0;

    assign pass_count = passes;
    assign fail_count = fails;

    function automatic string test_name(input int id);
        string base;
        case (id % 6)
            0:       base = "alu_ops";
            1:       base = "forwarding";
            2:       base = "load_use";
            3:       base = "ecall_nop";
            4:       base = "ecall_x17_dep";
            default: base = "reset_reload";
        endcase
        return $sformatf("%s_%0d", base, id);
    endfunction

    // outputs settled by the falling edge
    always @(negedge clk) begin : watch
        int errs;
        errs = 0;
        if (reset) begin
            armed       <= 1'b1;
            first_cycle <= 1'b1;
            test_done   <= 1'b0;
        end else begin
            first_cycle <= 1'b0;
            if (first_cycle && is_halted) begin
                $display("ERROR %s: is_halted already high right after reset",
                         test_name(test_id));
                errs++;
            end
            if (armed && is_halted) begin
                for (int r = 0; r < num_regs; r++) begin
                    if (print_reg[r] !== exp_regs[r]) begin
                        $display("MISMATCH %s x%0d expected %08h actual %08h",
                                 test_name(test_id), r, exp_regs[r], print_reg[r]);
                        errs++;
                    end
                end
                if (errs == 0) begin
                    passes++;
                    $display("PASS %s", test_name(test_id));
                end else begin
                    fails++;
                    $display("FAIL %s: %0d error(s)", test_name(test_id), errs);
                end
                armed     <= 1'b0;  // later halts ignored until next reset
                test_done <= 1'b1;
            end
        end
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

    typedef enum logic [2:0] {k_reg, k_imm, k_load, k_store, k_ecall} kind_e;

    // one program instruction in fields for the model
    typedef struct packed {
        kind_e                 kind;
        alu_op_e               fn;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;   // sign-extended imm or memory byte offset
    } instr_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  load_en;
    logic [mem_addr_w-1:0] load_addr;
    logic [xlen-1:0]       load_data;
    logic                  is_halted;
    logic [xlen-1:0]       print_reg [num_regs];
    logic [xlen-1:0]       exp_regs [num_regs];     // model register state
    logic [xlen-1:0]       model_mem [mem_words];
    logic                  test_done;
    instr_t                prog [mem_words];
    int                    prog_len;
    int                    stored [$];              // word indices stored this test
    int                    seed;
    int                    test_id;
    int                    pass_count, fail_count;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;         // grows as each test is built
    int                    num_tests   = 12;
    int                    body_len    = 40;

    cpu_top UUT (.clk, .reset, .load_en, .load_addr, .load_data, .is_halted, .print_reg);

    tb_checker chk (.clk, .reset, .is_halted, .print_reg, .exp_regs, .test_id,
                    .test_done, .pass_count, .fail_count);

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("TIMEOUT: processor never halted within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int urand(input int range);
        return int'({$random(seed)} % 32'(range));
    endfunction

    function automatic instr_t make_op(input kind_e k, input alu_op_e fn, input int rd,
                                       input int rs1, input int rs2,
                                       input logic [xlen-1:0] imm);
        instr_t in;
        in.kind = k;
        in.fn   = fn;
        in.rd   = reg_addr_w'(rd);
        in.rs1  = reg_addr_w'(rs1);
        in.rs2  = reg_addr_w'(rs2);
        in.imm  = imm;
        return in;
    endfunction

    // RV32I funct3 per function
    function automatic logic [2:0] funct3_of(input alu_op_e fn);
        case (fn)
            alu_sll:          return 3'b001;
            alu_slt:          return 3'b010;
            alu_sltu:         return 3'b011;
            alu_xor:          return 3'b100;
            alu_srl, alu_sra: return 3'b101;
            alu_or:           return 3'b110;
            alu_and:          return 3'b111;
            default:          return 3'b000;  // add, sub
        endcase
    endfunction

    function automatic logic [xlen-1:0] encode(input instr_t in);
        logic [2:0] f3;
        logic       alt;
        f3  = funct3_of(in.fn);
        alt = (in.fn == alu_sub) || (in.fn == alu_sra);
        case (in.kind)
            k_reg:   return {1'b0, alt, 5'd0, in.rs2, in.rs1, f3, in.rd, op_reg};
            k_imm:   return {in.imm[11:0], in.rs1, f3, in.rd, op_imm};
            k_load:  return {in.imm[11:0], 5'd0, 3'b010, in.rd, op_load};
            k_store: return {in.imm[11:5], in.rs2, 5'd0, 3'b010, in.imm[4:0], op_store};
            default: return {25'd0, op_system};  // ecall
        endcase
    endfunction

    // RV32I ALU semantics
    function automatic logic [xlen-1:0] alu_ref(input alu_op_e fn, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (fn)
            alu_sub:  return a - b;
            alu_sll:  return a << sh;
            alu_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            alu_sltu: return {31'd0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return a + b;
        endcase
    endfunction

    function automatic instr_t random_instr(input int mode, input int i);
        instr_t      in;
        logic [11:0] raw;
        int          pick;
        int          word;
        pick = urand(100);
        raw  = 12'(urand(4096));
        in   = make_op(k_reg, alu_op_e'(4'(urand(10))), 1 + urand(8), 1 + urand(8),
                       1 + urand(8), {{20{raw[11]}}, raw});
        if (i < 8 && mode != 5) begin  // mode 5 reads the reset register file
            in.kind = k_imm;  // seed x1..x8 with constants
            in.fn   = alu_add;
            in.rd   = reg_addr_w'(i + 1);
            in.rs1  = '0;
        end else if (pick < ((mode == 2) ? 45 : (mode == 5) ? 20 : 0)) begin
            in.rs1 = '0;  // base x0
            if (stored.size() == 0 || pick % 3 == 0) begin
                in.kind = k_store;
                word    = urand(mem_words);
                stored.push_back(word);
                if (prog[prog_len-1].kind == k_load)
                    in.rs2 = prog[prog_len-1].rd;  // store data right after a load
            end else begin
                in.kind = k_load;  // only from words this program wrote
                word    = stored[urand(stored.size())];
            end
            in.imm = 32'(word * 4);
        end else begin
            if (pick % 2 == 1) begin
                in.kind = k_imm;
                if (in.fn == alu_sub)
                    in.fn = alu_add;  // no subi
                if (in.fn == alu_sll || in.fn == alu_srl || in.fn == alu_sra)
                    in.imm = (in.fn == alu_sra ? 32'h400 : 32'h0) | 32'(raw[4:0]);
            end
            if (mode == 1) begin
                in.rs1 = prog[prog_len-1].rd;  // distance one
                in.rs2 = prog[prog_len-2].rd;  // distance two
                if (pick < 12)
                    in.rd = '0;
            end
            if (mode == 2 && prog[prog_len-1].kind == k_load)
                in.rs1 = prog[prog_len-1].rd;
        end
        return in;
    endfunction

    task automatic add_instr(input instr_t in);
        prog[prog_len] = in;
        prog_len++;
    endtask

    // six modes for alu, forwarding, load-use, ecall nop, ecall dependency and reset reload
    task automatic build_program(input int t);
        int mode;
        mode     = t % 6;
        prog_len = 0;
        stored.delete();
        if (mode == 3)
            add_instr(make_op(k_imm, alu_add, halt_reg, 0, 0, 32'(16 + urand(200))));
        else if (mode != 4)
            add_instr(make_op(k_imm, alu_add, halt_reg, 0, 0, halt_code));
        for (int i = 0; i < body_len; i++) begin
            if (mode == 3 && i == body_len / 2)
                add_instr(make_op(k_ecall, alu_add, 0, 0, 0, '0));  // x17 not 10 yet
            add_instr(random_instr(mode, i));
        end
        if (mode == 3 || mode == 4)
            add_instr(make_op(k_imm, alu_add, halt_reg, 0, 0, halt_code));
        if (mode == 3) begin
            add_instr(random_instr(mode, body_len));
            add_instr(random_instr(mode, body_len));
        end
        add_instr(make_op(k_ecall, alu_add, 0, 0, 0, '0));
        repeat (8) add_instr(make_op(k_imm, alu_add, 0, 0, 0, '0));  // nop padding
        cycle_limit += 3 * prog_len + 30;
    endtask

    // in-order run up to the halting ecall
    task automatic run_model();
        instr_t          in;
        logic [xlen-1:0] res;
        logic            wr;
        for (int r = 0; r < num_regs; r++)
            exp_regs[r] = '0;
        for (int i = 0; i < prog_len; i++) begin
            in  = prog[i];
            wr  = 1'b1;
            res = '0;
            case (in.kind)
                k_reg:  res = alu_ref(in.fn, exp_regs[in.rs1], exp_regs[in.rs2]);
                k_imm:  res = alu_ref(in.fn, exp_regs[in.rs1], in.imm);
                k_load: res = model_mem[in.imm[9:2]];
                k_store: begin
                    model_mem[in.imm[9:2]] = exp_regs[in.rs2];
                    wr = 1'b0;
                end
                default: begin
                    wr = 1'b0;
                    if (exp_regs[halt_reg] == halt_code)
                        break;
                end
            endcase
            if (wr && in.rd != '0)
                exp_regs[in.rd] = res;
        end
    endtask

    task automatic load_program(input int t);
        @(posedge clk);
        reset   <= 1'b1;
        test_id <= t;
        repeat (10) @(posedge clk);
        for (int i = 0; i < prog_len; i++) begin
            load_en   <= 1'b1;  // reset still held
            load_addr <= mem_addr_w'(i);
            load_data <= encode(prog[i]);
            @(posedge clk);
        end
        load_en <= 1'b0;
        reset   <= 1'b0;
    endtask

    initial begin
        seed      = 32'h363f_ad5f;
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_id   = 0;
        for (int t = 0; t < num_tests; t++) begin
            build_program(t);
            run_model();
            load_program(t);
            @(posedge clk);
            while (!test_done)
                @(posedge clk);
        end
        $display("tests passed: %0d  failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == num_tests)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* sim.f */
cpu_pkg.sv
pipe_control.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
TOP        ?= tb_top
SEED_FLAGS ?= +verilator+seed+1
LOG        ?= sim.log
VERILATOR  ?= verilator
OBJ_DIR    ?= obj_dir

SRCS := $(shell cat sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): sim.f $(SRCS)
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

# pass or fail is taken from the log
run: compile
	./$(BIN) $(SEED_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
